/* filelist.f */
+incdir+tb
logic/f8_pkg.sv
logic/f8_regfile.sv
logic/f8_decoder.sv
logic/f8_alu.sv
logic/f8_fetch.sv
logic/f8_execute.sv
logic/f8_core.sv
tb/f8_core_chk.sv
tb/f8_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := f8_core_tb
FILELIST := filelist.f
OBJ_DIR := obj_dir
FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/f8_ref_model.svh */
/* f8 reference model and program builder
   runs a program one instruction at a time and records the stores it makes */

function automatic logic [15:0] mem_word(input logic [15:0] a);
	logic [15:0] a1;
	a1 = a + 16'd1;
	return {ref_mem[a1], ref_mem[a]};
endfunction

function automatic void record_store(input logic [15:0] a, input logic [1:0] en,
	input logic [15:0] d);
	logic [15:0] a1;
	a1 = a + 16'd1;
	if (en[0])
		ref_mem[a] = d[7:0];
	if (en[1])
		ref_mem[a1] = d[15:8];
	exp_q.push_back('{addr: a, en: en, data: d});
endfunction

function automatic void reference_run(output logic reached_trap);
	logic [15:0] pc, prev_pc, nxt, x, y, z, w, imm;
	logic [7:0] op, a, b, bv, r;
	logic [8:0] r9;
	logic [16:0] r17;
	logic fo, fz, fn, fc, taken;
	pc = RESET_PC;
	prev_pc = RESET_PC;
	x = '0;
	y = '0;
	z = '0;
	{fo, fz, fn, fc} = 4'b0000;
	reached_trap = 1'b0;
	for (int step = 0; step < 4000 && !reached_trap; step++)
	begin
		op = imem[pc];
		b = imem[pc + 16'd1];
		imm = {imem[pc + 16'd2], b};
		nxt = pc + 16'd1;
		a = x[7:0];
		case (op)
			OP_ADD_XL_IMM, OP_ADD_XL_DIR, OP_SUB_XL_IMM, OP_SUB_XL_DIR, OP_AND_XL_IMM,
			OP_AND_XL_DIR, OP_OR_XL_IMM, OP_OR_XL_DIR, OP_XOR_XL_IMM, OP_XOR_XL_DIR,
			OP_CP_XL_IMM, OP_CP_XL_DIR:
			begin
				// odd opcodes take a direct address
				w = mem_word(imm);
				bv = op[0] ? w[7:0] : b;
				nxt = pc + (op[0] ? 16'd3 : 16'd2);
				if (op <= OP_ADD_XL_DIR)
				begin
					r9 = {1'b0, a} + {1'b0, bv};
					fo = (a[7] == bv[7]) && (r9[7] != a[7]);
					fc = r9[8];
				end
				else if (op <= OP_SUB_XL_DIR || op >= OP_CP_XL_IMM)
				begin
					r9 = {1'b0, a} - {1'b0, bv};
					fo = (a[7] != bv[7]) && (r9[7] != a[7]);
					fc = r9[8];
				end
				else
					r9 = {1'b0, (op <= OP_AND_XL_DIR) ? (a & bv) :
						(op <= OP_OR_XL_DIR) ? (a | bv) : (a ^ bv)};
				fz = (r9[7:0] == 8'h00);
				fn = r9[7];
				if (op < OP_CP_XL_IMM)
					x[7:0] = r9[7:0];
			end
			OP_INC_XL, OP_DEC_XL:
			begin
				r = (op == OP_INC_XL) ? a + 8'd1 : a - 8'd1;
				fo = (op == OP_INC_XL) ? (!a[7] && r[7]) : (a[7] && !r[7]);
				fz = (r == 8'h00);
				fn = r[7];
				x[7:0] = r;
			end
			OP_LD_XL_IMM, OP_LD_XL_DIR, OP_LD_XL_YREL:
			begin
				w = (op == OP_LD_XL_DIR) ? mem_word(imm) : mem_word(y + {8'h00, b});
				r = (op == OP_LD_XL_IMM) ? b : w[7:0];
				nxt = pc + ((op == OP_LD_XL_DIR) ? 16'd3 : 16'd2);
				fz = (r == 8'h00);
				fn = r[7];
				x[7:0] = r;
			end
			OP_LD_DIR_XL:
			begin
				record_store(imm, 2'b01, {8'h00, a});
				nxt = pc + 16'd3;
			end
			OP_LDW_Y_IMM, OP_LDW_Y_DIR:
			begin
				y = (op == OP_LDW_Y_IMM) ? imm : mem_word(imm);
				fz = (y == 16'h0000);
				fn = y[15];
				nxt = pc + 16'd3;
			end
			OP_LDW_DIR_Y:
			begin
				record_store(imm, 2'b11, y);
				nxt = pc + 16'd3;
			end
			OP_ADDW_Y_D:
			begin
				r17 = {1'b0, y} + {1'b0, {8{b[7]}}, b};
				fo = (y[15] == b[7]) && (r17[15] != y[15]);
				fc = r17[16];
				y = r17[15:0];
				fz = (y == 16'h0000);
				fn = y[15];
				nxt = pc + 16'd2;
			end
			OP_LDW_X_Y:
				x = y;
			OP_LDW_Z_Y:
				z = y;
			OP_JP_IMM:
				nxt = imm;
			OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
			begin
				taken = (op == OP_JR_D) || (op == OP_JRZ_D && fz) || (op == OP_JRNZ_D && !fz) ||
					(op == OP_JRC_D && fc) || (op == OP_JRNC_D && !fc);
				// displacement counts from the instruction before the jump
				nxt = taken ? prev_pc + {{8{b[7]}}, b} : pc + 16'd2;
			end
			OP_TRAP:
				reached_trap = 1'b1;
			default:
				nxt = pc + 16'd1;
		endcase
		prev_pc = pc;
		pc = nxt;
	end
endfunction

task automatic put_byte(input logic [7:0] v);
	imem[prog_pc] = v;
	prog_pc = prog_pc + 16'd1;
endtask

task automatic one_byte_inst(input opcode_t op);
	last_addr = prog_pc;
	put_byte(op);
endtask

task automatic inst_with_byte(input opcode_t op, input logic [7:0] v);
	one_byte_inst(op);
	put_byte(v);
endtask

task automatic inst_with_word(input opcode_t op, input logic [15:0] v);
	one_byte_inst(op);
	put_byte(v[7:0]);
	put_byte(v[15:8]);
endtask

// jump over one byte store, then a nop so no jump follows a skipped instruction
task automatic skip_store_if(input opcode_t op, input logic [15:0] addr);
	if (op == OP_JP_IMM)
		inst_with_word(op, prog_pc + 16'd6);
	else
		inst_with_byte(op, 8'(prog_pc + 16'd5 - last_addr));
	inst_with_word(OP_LD_DIR_XL, addr);
	one_byte_inst(OP_NOP);
endtask

/* tb/f8_core_tb.sv */
/* f8 core testbench
   directed and random programs, every store checked against the reference model */

`timescale 1ns/1ps

module f8_core_tb import f8_pkg::*; ();
	localparam logic [15:0] RESET_PC = 16'h4000;
	localparam opcode_t ALU_IMM_OPS [6] = '{OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM,
		OP_OR_XL_IMM, OP_XOR_XL_IMM, OP_CP_XL_IMM};
	localparam opcode_t COND_OPS [6] = '{OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D,
		OP_JR_D, OP_JP_IMM};

	typedef struct packed {
		logic [15:0] addr;
		logic [1:0] en;
		logic [15:0] data;
	} store_rec_t;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data = '0;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [65536];
	logic [7:0] dmem [65536];
	logic [7:0] ref_mem [65536];
	store_rec_t exp_q [$];
	logic [15:0] prog_pc;
	logic [15:0] last_addr;
	integer seed;
	string test_name;
	logic trap_seen = 1'b0;

	`include "f8_ref_model.svh"

	f8_core #(.RESET_PC(RESET_PC)) uut (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	assign iread_data = {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};

	// data memory, write-first
	always @(posedge clk)
	begin
		if (dwrite_en[0])
			dmem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] = dwrite_data[15:8];
		dread_data <= {dmem[dread_addr + 16'd1], dmem[dread_addr]};
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	always @(negedge clk)
	begin
		store_rec_t got;
		store_rec_t want;
		if (reset)
			trap_seen = 1'b0;
		else if (!trap_seen)
		begin
			if (dwrite_en != 2'b00)
			begin
				got = '{addr: dwrite_addr, en: dwrite_en, data: dwrite_data};
				assert (exp_q.size() > 0)
				else
					fail_run($sformatf("%s: store to %h that the program should not make",
						test_name, dwrite_addr));
				want = exp_q.pop_front();
				assert (got == want)
				else
					fail_run($sformatf("** Error %s: expected %h/%b/%h actual %h/%b/%h",
						test_name, want.addr, want.en, want.data, got.addr, got.en, got.data));
			end
			if (trap === 1'b1)
				trap_seen = 1'b1;
		end
	end

	task automatic fill_data();
		for (int a = 0; a < 65536; a++)
			dmem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
		for (int a = 16'h0100; a < 16'h0200; a++)
			dmem[a] = 8'($random(seed));
	endtask

	task automatic start_reset();
		@(negedge clk);
		reset = 1'b1;
		for (int a = 0; a < 65536; a++)
			imem[a] = 8'h00;
		prog_pc = RESET_PC;
		last_addr = RESET_PC;
		fill_data();
	endtask

	task automatic run_program(input string name);
		logic hit;
		test_name = name;
		exp_q.delete();
		ref_mem = dmem;
		reference_run(hit);
		assert (hit)
		else
			fail_run({name, ": reference model never reached trap"});
		for (int i = 0; i < 16; i++)
		begin
			@(negedge clk);
			assert (iread_addr == RESET_PC && dwrite_en == 2'b00 && trap == 1'b0)
			else
				fail_run($sformatf("** Error %s: expected %h/00/0 actual %h/%b/%b in reset",
					name, RESET_PC, iread_addr, dwrite_en, trap));
		end
		reset = 1'b0;
		for (int i = 0; i < 2000 && !trap_seen; i++)
			@(negedge clk);
		assert (trap_seen)
		else
			fail_run({name, ": timeout, trap did not rise within 2000 cycles"});
		assert (exp_q.size() == 0)
		else
			fail_run({name, ": trap came before all expected stores were seen"});
	endtask

	initial
	begin
		logic [7:0] v;
		logic [7:0] w;
		int k;
		seed = 32'ha59b;
		reset = 1'b1;

		start_reset();
		inst_with_byte(OP_LD_XL_IMM, 8'h5a);
		inst_with_word(OP_LDW_Y_IMM, 16'h1234);
		inst_with_word(OP_LD_DIR_XL, 16'h0200);
		inst_with_word(OP_LDW_DIR_Y, 16'h0202);
		inst_with_word(OP_LD_DIR_XL, 16'h0204);
		one_byte_inst(OP_TRAP);
		run_program("reset_stores");

		start_reset();
		for (int i = 0; i < 24; i++)
		begin
			inst_with_byte(OP_LD_XL_IMM, 8'($random(seed)));
			k = pick(7);
			if (k == 5)
				one_byte_inst(OP_INC_XL);
			else if (k == 6)
				one_byte_inst(OP_DEC_XL);
			else if (pick(2) == 0)
				inst_with_byte(ALU_IMM_OPS[k], 8'($random(seed)));
			else
				inst_with_word(opcode_t'(ALU_IMM_OPS[k] | 8'h01), 16'h0100 + 16'(pick(256)));
			inst_with_word(OP_LD_DIR_XL, 16'h0200 + 16'(i));
		end
		one_byte_inst(OP_TRAP);
		run_program("alu8");

		start_reset();
		for (int i = 0; i < 16; i++)
		begin
			v = 8'($random(seed));
			w = (i % 4 == 0) ? v : (i % 4 == 1) ? 8'(-v) : 8'($random(seed));
			inst_with_byte(OP_LD_XL_IMM, v);
			inst_with_byte((i % 2 == 0) ? OP_CP_XL_IMM : OP_ADD_XL_IMM, w);
			skip_store_if(COND_OPS[i / 4], 16'h0300 + 16'(i));
			inst_with_word(OP_LD_DIR_XL, 16'h0380 + 16'(i));
		end
		skip_store_if(OP_JR_D, 16'h03f0);
		skip_store_if(OP_JP_IMM, 16'h03f1);
		one_byte_inst(OP_TRAP);
		run_program("flags_branch");

		start_reset();
		inst_with_word(OP_LDW_Y_IMM, 16'h0210);
		inst_with_byte(OP_ADDW_Y_D, 8'h7f);
		inst_with_word(OP_LDW_DIR_Y, 16'h0220);
		one_byte_inst(OP_LDW_X_Y);
		inst_with_word(OP_LD_DIR_XL, 16'h0224);
		one_byte_inst(OP_LDW_Z_Y);
		inst_with_word(OP_LDW_Y_IMM, 16'h8000);
		inst_with_byte(OP_ADDW_Y_D, 8'h80);
		skip_store_if(OP_JRNC_D, 16'h0240);
		// the next load reads the low byte of this word back
		inst_with_word(OP_LDW_DIR_Y, 16'h0221);
		inst_with_word(OP_LDW_Y_DIR, 16'h0220);
		inst_with_word(OP_LDW_DIR_Y, 16'h0228);
		inst_with_word(OP_LDW_Y_IMM, 16'h0200);
		inst_with_byte(OP_LD_XL_YREL, 8'h20);
		inst_with_word(OP_LD_DIR_XL, 16'h022a);
		inst_with_word(OP_LD_DIR_XL, 16'h0230);
		inst_with_byte(OP_ADD_XL_IMM, 8'h11);
		inst_with_word(OP_LD_XL_DIR, 16'h0230);
		inst_with_word(OP_LD_DIR_XL, 16'h0232);
		one_byte_inst(OP_TRAP);
		run_program("word_path");

		start_reset();
		inst_with_byte(OP_LD_XL_IMM, 8'($random(seed)));
		inst_with_word(OP_LDW_Y_IMM, 16'h0100 + 16'(pick(256)));
		for (int i = 0; i < 48; i++)
		begin
			k = pick(13);
			case (k)
				0: inst_with_byte(ALU_IMM_OPS[pick(6)], 8'($random(seed)));
				1: inst_with_word(opcode_t'(ALU_IMM_OPS[pick(6)] | 8'h01),
					16'h0100 + 16'(pick(512)));
				2: one_byte_inst((pick(2) == 0) ? OP_INC_XL : OP_DEC_XL);
				3: inst_with_byte(OP_LD_XL_IMM, 8'($random(seed)));
				4: inst_with_word(OP_LD_XL_DIR, 16'h0100 + 16'(pick(512)));
				5: inst_with_byte(OP_LD_XL_YREL, 8'(pick(256)));
				6: inst_with_word(OP_LD_DIR_XL, 16'h0200 + 16'(pick(256)));
				7: inst_with_word(OP_LDW_Y_IMM, 16'h0100 + 16'(pick(512)));
				8: inst_with_word(OP_LDW_Y_DIR, 16'h0100 + 16'(pick(512)));
				9: inst_with_word(OP_LDW_DIR_Y, 16'h0200 + 16'(pick(256)));
				10: inst_with_byte(OP_ADDW_Y_D, 8'($random(seed)));
				11: one_byte_inst((pick(2) == 0) ? OP_LDW_X_Y : OP_LDW_Z_Y);
				default: skip_store_if(COND_OPS[pick(6)], 16'h0200 + 16'(pick(256)));
			endcase
		end
		one_byte_inst(OP_TRAP);
		run_program("random_program");

		$display("Done: no errors");
		$finish;
	end
endmodule

/* tb/f8_core_chk.sv */
/* f8 core reset checker
   bound to the core, watches the memory ports while reset is held */

`timescale 1ns/1ps

module f8_core_chk #(
	parameter logic [15:0] RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	input logic [15:0] iread_addr,
	input logic [1:0] dwrite_en,
	input logic trap
);
	logic armed = 1'b0;

	always @(posedge clk)
		armed <= 1'b1;

	// one edge into reset the core has loaded its reset state
	a_reset_pc: assert property (@(posedge clk)
		armed && reset && $past(reset) |-> iread_addr == RESET_PC)
		else $error("iread_addr differs from RESET_PC while reset is held");

	a_reset_write: assert property (@(posedge clk)
		armed && reset && $past(reset) |-> dwrite_en == 2'b00)
		else $error("data write enabled while reset is held");

	a_reset_trap: assert property (@(posedge clk)
		armed && reset && $past(reset) |-> !trap)
		else $error("trap high while reset is held");
endmodule

bind f8_core f8_core_chk #(.RESET_PC(RESET_PC)) u_chk (
	.clk(clk),
	.reset(reset),
	.iread_addr(iread_addr),
	.dwrite_en(dwrite_en),
	.trap(trap)
);

/* logic/f8_core.sv */
/* f8 single-cycle core
   fetch, execute and register file on fixed memory ports without handshakes */

`timescale 1ns/1ps

module f8_core import f8_pkg::*;
#(
	parameter logic [WORD_W-1:0] RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	output logic [WORD_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	output logic [WORD_W-1:0] dread_addr,
	input logic [WORD_W-1:0] dread_data,
	output logic [WORD_W-1:0] dwrite_addr,
	output logic [WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	ctrl_t exe_ctrl;
	logic [WORD_W-1:0] exe_imm;
	flags_t next_flags;
	regs_t regs;
	regs_t next_regs;
	reg_write_t reg_write;

	f8_fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.next_regs(next_regs),
		.dread_addr(dread_addr),
		.exe_ctrl(exe_ctrl),
		.exe_imm(exe_imm),
		.exe_pc()
	);

	f8_execute u_execute (
		.clk(clk),
		.reset(reset),
		.exe_ctrl(exe_ctrl),
		.exe_imm(exe_imm),
		.regs(regs),
		.dread_data(dread_data),
		.next_flags(next_flags),
		.reg_write(reg_write),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	f8_regfile u_regfile (
		.clk(clk),
		.reg_write(reg_write),
		.regs(regs),
		.next_regs(next_regs)
	);
endmodule

/* logic/f8_execute.sv */
/* f8 execute stage
   operand select, ALU, flag register, register writeback and data write port */

`timescale 1ns/1ps

module f8_execute import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t exe_ctrl,
	input logic [WORD_W-1:0] exe_imm,
	input regs_t regs,
	input logic [WORD_W-1:0] dread_data,
	output flags_t next_flags,
	output reg_write_t reg_write,
	output logic [WORD_W-1:0] dwrite_addr,
	output logic [WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	flags_t flags;
	flags_t alu_flags;
	logic [WORD_W-1:0] op_a;
	logic [WORD_W-1:0] op_b;
	logic [WORD_W-1:0] result;

	function automatic logic [WORD_W-1:0] operand(input op_src_t src,
		input logic [WORD_W-1:0] imm, input logic [WORD_W-1:0] mem, input regs_t r);
		logic [WORD_W-1:0] val;
		case (src)
			SRC_IMM8:
				val = {{BYTE_W{imm[BYTE_W-1]}}, imm[BYTE_W-1:0]};
			SRC_IMM16:
				val = imm;
			SRC_MEM:
				val = mem;
			SRC_XL:
				val = {{BYTE_W{1'b0}}, r.x[BYTE_W-1:0]};
			SRC_Y:
				val = r.y;
			default:
				val = '0;
		endcase
		return val;
	endfunction

	assign op_a = operand(exe_ctrl.src_a, exe_imm, dread_data, regs);
	assign op_b = operand(exe_ctrl.src_b, exe_imm, dread_data, regs);

	f8_alu u_alu (
		.op(exe_ctrl.alu_op),
		.a(op_a),
		.b(op_b),
		.result(result),
		.flags_out(alu_flags)
	);

	// only masked flags take the new value
	assign next_flags = (alu_flags & exe_ctrl.flag_mask) | (flags & ~exe_ctrl.flag_mask);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= FLAGS_NONE;
		else
			flags <= next_flags;
	end

	always_comb
	begin
		reg_write.data = result;
		case (exe_ctrl.dst)
			DST_XL:
				{reg_write.sel, reg_write.byte_en} = {2'd0, 2'b01};
			DST_Y:
				{reg_write.sel, reg_write.byte_en} = {2'd1, 2'b11};
			DST_X:
				{reg_write.sel, reg_write.byte_en} = {2'd0, 2'b11};
			DST_Z:
				{reg_write.sel, reg_write.byte_en} = {2'd2, 2'b11};
			default:
				{reg_write.sel, reg_write.byte_en} = {2'd0, 2'b00};
		endcase
	end

	assign dwrite_addr = exe_imm;
	assign dwrite_data = result;
	assign dwrite_en = (exe_ctrl.store == ST_WORD) ? 2'b11 :
		(exe_ctrl.store == ST_BYTE) ? 2'b01 : 2'b00;
	assign trap = exe_ctrl.is_trap;
endmodule

/* logic/f8_fetch.sv */
/* f8 fetch stage
   program counter, branch resolution, data read address and instruction register */

`timescale 1ns/1ps

module f8_fetch import f8_pkg::*;
#(
	parameter logic [WORD_W-1:0] RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	output logic [WORD_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	input flags_t next_flags,
	input regs_t next_regs,
	output logic [WORD_W-1:0] dread_addr,
	output ctrl_t exe_ctrl,
	output logic [WORD_W-1:0] exe_imm,
	output logic [WORD_W-1:0] exe_pc
);
	ctrl_t dec_ctrl;
	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] next_pc;
	logic [WORD_W-1:0] seq_pc;
	logic [WORD_W-1:0] rel_pc;
	logic [BYTE_W-1:0] disp;

	f8_decoder u_decoder (
		.inst(iread_data),
		.ctrl(dec_ctrl)
	);

	assign disp = iread_data[2*BYTE_W-1:BYTE_W];
	assign seq_pc = pc + WORD_W'(dec_ctrl.length);
	// relative target counts from the instruction now executing
	assign rel_pc = exe_pc + {{BYTE_W{disp[BYTE_W-1]}}, disp};

	always_comb
	begin
		case (dec_ctrl.branch)
			BR_JP:
				next_pc = iread_data[INST_W-1:BYTE_W];
			BR_JR:
				next_pc = rel_pc;
			BR_JRZ:
				next_pc = next_flags.z ? rel_pc : seq_pc;
			BR_JRNZ:
				next_pc = next_flags.z ? seq_pc : rel_pc;
			BR_JRC:
				next_pc = next_flags.c ? rel_pc : seq_pc;
			BR_JRNC:
				next_pc = next_flags.c ? seq_pc : rel_pc;
			default:
				next_pc = seq_pc;
		endcase
		if (reset)
			next_pc = RESET_PC;
	end

	always_comb
	begin
		case (dec_ctrl.rd_mode)
			RD_YREL:
				dread_addr = next_regs.y + {{BYTE_W{1'b0}}, disp};
			RD_DIR:
				dread_addr = iread_data[INST_W-1:BYTE_W];
			default:
				dread_addr = '0;
		endcase
	end

	assign iread_addr = pc;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		exe_pc <= pc;
		exe_imm <= iread_data[INST_W-1:BYTE_W];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			exe_ctrl <= CTRL_NOP;
		else
			exe_ctrl <= dec_ctrl;
	end
endmodule

/* logic/f8_alu.sv */
/* f8 ALU
   8-bit operations on the low byte, 16-bit add and pass, with o z n c flags */

`timescale 1ns/1ps

module f8_alu import f8_pkg::*;
(
	input alu_op_t op,
	input logic [WORD_W-1:0] a,
	input logic [WORD_W-1:0] b,
	output logic [WORD_W-1:0] result,
	output flags_t flags_out
);
	logic [BYTE_W-1:0] a_lo;
	logic [BYTE_W-1:0] b_lo;
	logic [BYTE_W:0] res8;
	logic [WORD_W:0] res16;
	logic ovf;
	logic word_op;

	assign a_lo = a[BYTE_W-1:0];
	assign b_lo = b[BYTE_W-1:0];

	always_comb
	begin
		res8 = {1'b0, a_lo};
		res16 = {1'b0, a};
		ovf = 1'b0;
		word_op = 1'b0;
		case (op)
			ALU_ADD:
			begin
				res8 = {1'b0, a_lo} + {1'b0, b_lo};
				ovf = (a_lo[BYTE_W-1] == b_lo[BYTE_W-1]) && (res8[BYTE_W-1] != a_lo[BYTE_W-1]);
			end
			ALU_SUB:
			begin
				// top bit ends up as the borrow
				res8 = {1'b0, a_lo} - {1'b0, b_lo};
				ovf = (a_lo[BYTE_W-1] != b_lo[BYTE_W-1]) && (res8[BYTE_W-1] != a_lo[BYTE_W-1]);
			end
			ALU_AND:
				res8 = {1'b0, a_lo & b_lo};
			ALU_OR:
				res8 = {1'b0, a_lo | b_lo};
			ALU_XOR:
				res8 = {1'b0, a_lo ^ b_lo};
			ALU_INC:
			begin
				res8 = {1'b0, a_lo} + 1'b1;
				ovf = !a_lo[BYTE_W-1] && res8[BYTE_W-1];
			end
			ALU_DEC:
			begin
				res8 = {1'b0, a_lo} - 1'b1;
				ovf = a_lo[BYTE_W-1] && !res8[BYTE_W-1];
			end
			ALU_ADDW:
			begin
				res16 = {1'b0, a} + {1'b0, b};
				ovf = (a[WORD_W-1] == b[WORD_W-1]) && (res16[WORD_W-1] != a[WORD_W-1]);
				word_op = 1'b1;
			end
			ALU_PASSW:
				word_op = 1'b1;
			default:
				res8 = {1'b0, a_lo};
		endcase

		if (word_op)
		begin
			result = res16[WORD_W-1:0];
			flags_out = '{o: ovf, z: (res16[WORD_W-1:0] == '0), n: res16[WORD_W-1],
				c: res16[WORD_W]};
		end
		else
		begin
			result = {a[WORD_W-1:BYTE_W], res8[BYTE_W-1:0]};
			flags_out = '{o: ovf, z: (res8[BYTE_W-1:0] == '0), n: res8[BYTE_W-1],
				c: res8[BYTE_W]};
		end
	end
endmodule

/* logic/f8_decoder.sv */
/* f8 instruction decoder
   maps one fetched instruction to its control word */

`timescale 1ns/1ps

module f8_decoder import f8_pkg::*;
(
	input logic [INST_W-1:0] inst,
	output ctrl_t ctrl
);
	opcode_t opcode;
	logic alu8;

	assign opcode = opcode_t'(inst[7:0]);

	always_comb
	begin
		ctrl = CTRL_NOP;
		alu8 = 1'b1;
		case (opcode)
			OP_ADD_XL_IMM, OP_ADD_XL_DIR:
				ctrl.alu_op = ALU_ADD;
			OP_SUB_XL_IMM, OP_SUB_XL_DIR, OP_CP_XL_IMM, OP_CP_XL_DIR:
				ctrl.alu_op = ALU_SUB;
			OP_AND_XL_IMM, OP_AND_XL_DIR:
				ctrl.alu_op = ALU_AND;
			OP_OR_XL_IMM, OP_OR_XL_DIR:
				ctrl.alu_op = ALU_OR;
			OP_XOR_XL_IMM, OP_XOR_XL_DIR:
				ctrl.alu_op = ALU_XOR;
			default:
				alu8 = 1'b0;
		endcase

		// two-operand group on xl
		if (alu8)
		begin
			ctrl.src_a = SRC_XL;
			ctrl.flag_mask = (ctrl.alu_op == ALU_ADD || ctrl.alu_op == ALU_SUB) ? FLAGS_ALL : FLAGS_ZN;
			ctrl.dst = (opcode == OP_CP_XL_IMM || opcode == OP_CP_XL_DIR) ? DST_NONE : DST_XL;
			if (inst[0])
			begin
				ctrl.src_b = SRC_MEM;
				ctrl.rd_mode = RD_DIR;
				ctrl.length = 2'd3;
			end
			else
			begin
				ctrl.src_b = SRC_IMM8;
				ctrl.length = 2'd2;
			end
		end

		case (opcode)
			OP_INC_XL, OP_DEC_XL:
			begin
				ctrl.alu_op = (opcode == OP_INC_XL) ? ALU_INC : ALU_DEC;
				ctrl.src_a = SRC_XL;
				ctrl.dst = DST_XL;
				ctrl.flag_mask = FLAGS_OZN;
			end
			OP_LD_XL_IMM, OP_LD_XL_DIR, OP_LD_XL_YREL:
			begin
				ctrl.src_a = (opcode == OP_LD_XL_IMM) ? SRC_IMM8 : SRC_MEM;
				ctrl.dst = DST_XL;
				ctrl.flag_mask = FLAGS_ZN;
				ctrl.rd_mode = (opcode == OP_LD_XL_DIR) ? RD_DIR :
					(opcode == OP_LD_XL_YREL) ? RD_YREL : RD_NONE;
				ctrl.length = (opcode == OP_LD_XL_DIR) ? 2'd3 : 2'd2;
			end
			OP_LD_DIR_XL:
			begin
				ctrl.src_a = SRC_XL;
				ctrl.store = ST_BYTE;
				ctrl.length = 2'd3;
			end
			OP_LDW_Y_IMM, OP_LDW_Y_DIR:
			begin
				ctrl.alu_op = ALU_PASSW;
				ctrl.src_a = (opcode == OP_LDW_Y_IMM) ? SRC_IMM16 : SRC_MEM;
				ctrl.rd_mode = (opcode == OP_LDW_Y_DIR) ? RD_DIR : RD_NONE;
				ctrl.dst = DST_Y;
				ctrl.flag_mask = FLAGS_ZN;
				ctrl.length = 2'd3;
			end
			OP_LDW_DIR_Y, OP_LDW_X_Y, OP_LDW_Z_Y:
			begin
				ctrl.alu_op = ALU_PASSW;
				ctrl.src_a = SRC_Y;
				ctrl.store = (opcode == OP_LDW_DIR_Y) ? ST_WORD : ST_NONE;
				ctrl.dst = (opcode == OP_LDW_X_Y) ? DST_X : (opcode == OP_LDW_Z_Y) ? DST_Z : DST_NONE;
				ctrl.length = (opcode == OP_LDW_DIR_Y) ? 2'd3 : 2'd1;
			end
			OP_ADDW_Y_D:
			begin
				ctrl.alu_op = ALU_ADDW;
				ctrl.src_a = SRC_Y;
				ctrl.src_b = SRC_IMM8;
				ctrl.dst = DST_Y;
				ctrl.flag_mask = FLAGS_ALL;
				ctrl.length = 2'd2;
			end
			OP_JP_IMM:
			begin
				ctrl.branch = BR_JP;
				ctrl.length = 2'd3;
			end
			OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
			begin
				ctrl.branch = (opcode == OP_JRZ_D) ? BR_JRZ : (opcode == OP_JRNZ_D) ? BR_JRNZ :
					(opcode == OP_JRC_D) ? BR_JRC : (opcode == OP_JRNC_D) ? BR_JRNC : BR_JR;
				ctrl.length = 2'd2;
			end
			OP_TRAP:
				ctrl.is_trap = 1'b1;
			default:
				alu8 = alu8;
		endcase
	end
endmodule

/* logic/f8_regfile.sv */
/* f8 register file
   x, y and z with byte write enables, plus the values after the pending write */

`timescale 1ns/1ps

module f8_regfile import f8_pkg::*;
(
	input logic clk,
	input reg_write_t reg_write,
	output regs_t regs,
	output regs_t next_regs
);
	logic [WORD_W-1:0] file_q [3];
	logic [WORD_W-1:0] file_d [3];

	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			file_d[i] = file_q[i];
			if (reg_write.sel == i[1:0])
			begin
				if (reg_write.byte_en[0])
					file_d[i][BYTE_W-1:0] = reg_write.data[BYTE_W-1:0];
				if (reg_write.byte_en[1])
					file_d[i][WORD_W-1:BYTE_W] = reg_write.data[WORD_W-1:BYTE_W];
			end
		end
	end

	always_ff @(posedge clk)
		file_q <= file_d;

	assign regs = '{x: file_q[0], y: file_q[1], z: file_q[2]};
	// forwarded view for address generation in fetch
	assign next_regs = '{x: file_d[0], y: file_d[1], z: file_d[2]};
endmodule

/* logic/f8_pkg.sv */
/* f8 core shared definitions
   opcodes of the kept subset, ALU operations, flags, registers and the control word */

package f8_pkg;
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;
	localparam int INST_W = 24;

	// even alu opcodes take an immediate, odd ones a direct address
	typedef enum logic [7:0] {
		OP_NOP = 8'h00, OP_TRAP = 8'h01,
		OP_ADD_XL_IMM = 8'h10, OP_ADD_XL_DIR = 8'h11,
		OP_SUB_XL_IMM = 8'h12, OP_SUB_XL_DIR = 8'h13,
		OP_AND_XL_IMM = 8'h14, OP_AND_XL_DIR = 8'h15,
		OP_OR_XL_IMM = 8'h16, OP_OR_XL_DIR = 8'h17,
		OP_XOR_XL_IMM = 8'h18, OP_XOR_XL_DIR = 8'h19,
		OP_CP_XL_IMM = 8'h1a, OP_CP_XL_DIR = 8'h1b,
		OP_INC_XL = 8'h1c, OP_DEC_XL = 8'h1d,
		OP_LD_XL_IMM = 8'h20, OP_LD_XL_DIR = 8'h21,
		OP_LD_XL_YREL = 8'h22, OP_LD_DIR_XL = 8'h23,
		OP_LDW_Y_IMM = 8'h30, OP_LDW_Y_DIR = 8'h31, OP_LDW_DIR_Y = 8'h32,
		OP_ADDW_Y_D = 8'h33, OP_LDW_X_Y = 8'h34, OP_LDW_Z_Y = 8'h35,
		OP_JP_IMM = 8'h40, OP_JR_D = 8'h41, OP_JRZ_D = 8'h42,
		OP_JRNZ_D = 8'h43, OP_JRC_D = 8'h44, OP_JRNC_D = 8'h45
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_INC, ALU_DEC, ALU_PASS, ALU_ADDW, ALU_PASSW
	} alu_op_t;

	typedef struct packed {
		logic o;
		logic z;
		logic n;
		logic c;
	} flags_t;

	typedef struct packed {
		logic [WORD_W-1:0] x;
		logic [WORD_W-1:0] y;
		logic [WORD_W-1:0] z;
	} regs_t;

	typedef struct packed {
		logic [1:0] sel;
		logic [1:0] byte_en;
		logic [WORD_W-1:0] data;
	} reg_write_t;

	typedef enum logic [2:0] {SRC_IMM8, SRC_IMM16, SRC_MEM, SRC_XL, SRC_Y, SRC_NONE} op_src_t;
	typedef enum logic [2:0] {BR_NONE, BR_JP, BR_JR, BR_JRZ, BR_JRNZ, BR_JRC, BR_JRNC} branch_t;
	typedef enum logic [1:0] {RD_NONE, RD_DIR, RD_YREL} rd_mode_t;
	typedef enum logic [2:0] {DST_NONE, DST_XL, DST_Y, DST_X, DST_Z} dst_t;
	typedef enum logic [1:0] {ST_NONE, ST_BYTE, ST_WORD} store_t;

	typedef struct packed {
		alu_op_t alu_op;
		op_src_t src_a;
		op_src_t src_b;
		dst_t dst;
		store_t store;
		flags_t flag_mask;
		branch_t branch;
		rd_mode_t rd_mode;
		logic [1:0] length;
		logic is_trap;
	} ctrl_t;

	localparam flags_t FLAGS_NONE = '{o: 1'b0, z: 1'b0, n: 1'b0, c: 1'b0};
	localparam flags_t FLAGS_ALL = '{o: 1'b1, z: 1'b1, n: 1'b1, c: 1'b1};
	localparam flags_t FLAGS_ZN = '{o: 1'b0, z: 1'b1, n: 1'b1, c: 1'b0};
	localparam flags_t FLAGS_OZN = '{o: 1'b1, z: 1'b1, n: 1'b1, c: 1'b0};

	localparam ctrl_t CTRL_NOP = '{alu_op: ALU_PASS, src_a: SRC_NONE, src_b: SRC_NONE,
		dst: DST_NONE, store: ST_NONE, flag_mask: FLAGS_NONE, branch: BR_NONE,
		rd_mode: RD_NONE, length: 2'd1, is_trap: 1'b0};
endpackage
